// ==== filelist.f ====
src/mutex_pkg.sv
src/mutex_port_arbiter.sv
src/mutex_table.sv
src/mutex_ack_gen.sv
src/mutex_bank.sv
testbench/mutex_checker.sv
testbench/tb_mutex_bank.sv

// ==== Makefile ====
# Verilator build and run of the mutex bank testbench

TOP = tb_mutex_bank

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the Verilator build directory and sim.log"

obj_dir/V$(TOP): filelist.f src/*.sv testbench/*.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f

# the log decides: the run passes only if the pass line is in it
test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^Testbench passed$$" sim.log && echo "result: pass" || \
		(echo "result: fail"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_mutex_bank.sv ====
/*
 * mutex bank testbench
 * drives both bus ports through directed and random lock traffic, keeps
 * a reference lock table and hands expected words to the checker
 */
`timescale 1ns/10ps

module tb_mutex_bank
	import mutex_pkg::*;
;

	localparam int MUTEX_COUNT = 32;
	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 400;
	localparam logic [31:0] SEED = 32'h5556e19f;

	logic clk;
	logic rst;
	logic [1:0] cs;
	logic [1:0] cyc;
	logic [1:0] stb;
	logic [1:0] we;
	logic [ADDR_W-1:0] adr [2];
	logic [DATA_W-1:0] dat_i [2];
	logic [1:0] ack;
	logic [DATA_W-1:0] dat_o [2];

	// expected word per port, set when that port sees its ack
	logic [DATA_W-1:0] exp_word [2];
	logic [DATA_W-1:0] ref_table [MUTEX_COUNT];
	logic [31:0] rng [2];

	int cycle;
	int checks;
	int errors;
	int lat_errors;
	int accesses;
	int tests_run;
	int checks_mark;
	int errs_mark;
	int ti0;
	int ta0;
	int tr0;
	int ti1;
	int ta1;
	int tr1;

	mutex_bank #(
		.MUTEX_COUNT(MUTEX_COUNT)
	) dut (
		.clk(clk),
		.rst(rst),
		.cs0(cs[0]),
		.cyc0(cyc[0]),
		.stb0(stb[0]),
		.we0(we[0]),
		.adr0(adr[0]),
		.dat_i0(dat_i[0]),
		.ack0(ack[0]),
		.dat_o0(dat_o[0]),
		.cs1(cs[1]),
		.cyc1(cyc[1]),
		.stb1(stb[1]),
		.we1(we[1]),
		.adr1(adr[1]),
		.dat_i1(dat_i[1]),
		.ack1(ack[1]),
		.dat_o1(dat_o[1])
	);

	mutex_checker chk (
		.clk(clk),
		.rst(rst),
		.ack(ack),
		.dat_o0(dat_o[0]),
		.dat_o1(dat_o[1]),
		.exp0(exp_word[0]),
		.exp1(exp_word[1]),
		.checks(checks),
		.errors(errors)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// cycle number of the rising edge that has just passed
	always @(posedge clk) cycle <= cycle + 1;

	// ============================================================
	// reference model and stimulus helpers
	// ============================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// a write commits only if the word is free or already the writer's,
	// and the written owner names the writer; the word after access returns
	function automatic logic [DATA_W-1:0] ref_access(input int p, input logic wr,
		input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
		int idx;
		lock_fields_t stored;
		lock_fields_t written;
		port_id_t me;
		idx = int'(addr[ADDR_LSB +: MAX_INDEX_W]) % MUTEX_COUNT;
		stored = ref_table[idx];
		written = wdata;
		me = port_id_t'(p);
		if (wr && (!stored.lock || stored.owner == me) && written.owner == me)
			ref_table[idx] = wdata;
		return ref_table[idx];
	endfunction

	function automatic logic [ADDR_W-1:0] word_addr(input int idx);
		return ADDR_W'(idx << ADDR_LSB);
	endfunction

	function automatic logic [DATA_W-1:0] lock_word(input int owner, input logic [15:0] tag,
		input logic lock);
		lock_fields_t f;
		f = '0;
		f.owner = port_id_t'(owner);
		f.tag = tag;
		f.lock = lock;
		return f;
	endfunction

	// entered a couple of ns after a rising edge and left the same way
	task automatic bus_access(input int p, input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output int t_issue, output int t_ack,
		output int t_release);
		cs[p] = 1'b1;
		cyc[p] = 1'b1;
		stb[p] = 1'b1;
		we[p] = wr;
		adr[p] = addr;
		dat_i[p] = wdata;
		t_issue = cycle;
		accesses++;
		@(posedge clk);
		#DRIVE_DELAY;
		while (!ack[p])
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		t_ack = cycle;
		// acks are serialized, so the model sees accesses in grant order
		exp_word[p] = ref_access(p, wr, addr, wdata);
		cs[p] = 1'b0;
		cyc[p] = 1'b0;
		stb[p] = 1'b0;
		we[p] = 1'b0;
		while (ack[p])
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		t_release = cycle;
	endtask

	// mostly claims with the port's own owner, now and then a foreign one
	task automatic random_traffic(input int p, input int count);
		logic [31:0] r;
		lock_fields_t f;
		int ti;
		int ta;
		int tr;
		for (int n = 0; n < count; n++)
		begin
			rng[p] = xorshift32(rng[p]);
			r = rng[p];
			rng[p] = xorshift32(rng[p]);
			f = lock_fields_t'(rng[p]);
			if (r[9:8] != 2'b00)
				f.owner = port_id_t'(p);
			else
				f.owner = r[13:10];
			repeat (int'(r[15:14]))
			begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
			// eight words only, with junk in the unused address bits
			bus_access(p, r[0], {r[27:24], 2'b00, r[18:16], r[23:22]}, f, ti, ta, tr);
		end
	endtask

	task automatic check_latency(input int p, input int got);
		if (got != 3)
		begin
			$display("ERROR %0t: port %0d ack came %0d cycles after its grant opportunity",
				$time, p, got);
			lat_errors++;
		end
	endtask

	// stb drops right after ack is seen, so ack must be gone one edge later
	task automatic check_release(input int p, input int got);
		if (got != 1)
		begin
			$display("ERROR %0t: port %0d ack stayed %0d cycles after stb fell",
				$time, p, got);
			lat_errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("test %0d %s: %0d checks, %0d errors", tests_run, name,
			checks - checks_mark, errors + lat_errors - errs_mark);
		checks_mark = checks;
		errs_mark = errors + lat_errors;
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		cs = '0;
		cyc = '0;
		stb = '0;
		we = '0;
		for (int p = 0; p < 2; p++)
		begin
			adr[p] = '0;
			dat_i[p] = '0;
			exp_word[p] = '0;
		end
		for (int i = 0; i < MUTEX_COUNT; i++)
			ref_table[i] = '0;
		rng[0] = SEED;
		rng[1] = xorshift32(SEED);
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		for (int i = 0; i < MUTEX_COUNT; i++)
			bus_access(i % 2, 1'b0, word_addr(i), '0, ti0, ta0, tr0);
		report_test("reset contents");

		bus_access(0, 1'b1, word_addr(3), lock_word(0, 16'ha5c3, 1'b1), ti0, ta0, tr0);
		bus_access(0, 1'b0, word_addr(3), '0, ti0, ta0, tr0);
		bus_access(1, 1'b1, word_addr(3), lock_word(1, 16'h1111, 1'b1), ti0, ta0, tr0);
		report_test("lock and contend");

		bus_access(1, 1'b1, word_addr(7), lock_word(0, 16'h0707, 1'b1), ti0, ta0, tr0);
		bus_access(0, 1'b1, word_addr(8), lock_word(2, 16'h0808, 1'b1), ti0, ta0, tr0);
		bus_access(0, 1'b0, word_addr(7), '0, ti0, ta0, tr0);
		report_test("foreign owner");

		bus_access(0, 1'b1, word_addr(3), lock_word(0, 16'ha5c3, 1'b0), ti0, ta0, tr0);
		bus_access(1, 1'b1, word_addr(3), lock_word(1, 16'h3131, 1'b1), ti0, ta0, tr0);
		bus_access(0, 1'b0, word_addr(3), '0, ti0, ta0, tr0);
		report_test("unlock and hand over");

		// port 1 becomes grantable on the edge where ack0 falls
		fork
			bus_access(0, 1'b1, word_addr(10), lock_word(0, 16'h0505, 1'b1), ti0, ta0, tr0);
			bus_access(1, 1'b1, word_addr(10), lock_word(1, 16'h1515, 1'b1), ti1, ta1, tr1);
		join
		check_latency(0, ta0 - ti0);
		check_latency(1, ta1 - tr0);
		check_release(0, tr0 - ta0);
		check_release(1, tr1 - ta1);
		fork
			bus_access(0, 1'b0, word_addr(11), '0, ti0, ta0, tr0);
			bus_access(1, 1'b1, word_addr(11), lock_word(1, 16'h1616, 1'b1), ti1, ta1, tr1);
		join
		check_latency(0, ta0 - ti0);
		check_latency(1, ta1 - tr0);
		check_release(0, tr0 - ta0);
		check_release(1, tr1 - ta1);
		report_test("same edge requests");

		fork
			random_traffic(0, 50);
			random_traffic(1, 50);
		join
		report_test("random traffic");

		if (checks != accesses)
		begin
			$display("the checker saw %0d acks but %0d accesses were made", checks, accesses);
			lat_errors++;
		end
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors + lat_errors);
		if (errors + lat_errors == 0 && checks > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// the whole run is bounded by a fixed cycle budget per test
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== testbench/mutex_checker.sv ====
/*
 * mutex bank response checker
 * watches both ack lines at the falling edge and compares every newly
 * acked word with the word the reference model expects
 */
`timescale 1ns/10ps

module mutex_checker
	import mutex_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [1:0] ack,
	input logic [DATA_W-1:0] dat_o0,
	input logic [DATA_W-1:0] dat_o1,
	input logic [DATA_W-1:0] exp0,
	input logic [DATA_W-1:0] exp1,
	output int checks,
	output int errors
);

	// ack level seen at the previous falling edge
	logic [1:0] ack_seen;
	logic [DATA_W-1:0] got [2];
	logic [DATA_W-1:0] want [2];

	assign got[0] = dat_o0;
	assign got[1] = dat_o1;
	assign want[0] = exp0;
	assign want[1] = exp1;

	// ============================================================
	// compare at the falling edge, where the DUT outputs are stable
	// ============================================================

	always @(negedge clk)
	begin
		if (rst)
		begin
			ack_seen = '0;
		end
		else
		begin
			// only one access is in flight at a time
			if (ack == 2'b11)
			begin
				$display("ERROR %0t: both ports acknowledged in the same cycle", $time);
				errors++;
			end
			for (int p = 0; p < 2; p++)
			begin
				if (ack[p] && !ack_seen[p])
				begin
					// a fresh ack, so the expected word is already in place
					checks++;
					if (got[p] !== want[p])
					begin
						$display("ERROR %0t: port %0d returned %h, expected %h",
							$time, p, got[p], want[p]);
						errors++;
					end
				end
				else if (!ack[p] && got[p] !== '0)
				begin
					$display("ERROR %0t: port %0d drives data %h while ack is low",
						$time, p, got[p]);
					errors++;
				end
			end
			ack_seen = ack;
		end
	end

endmodule

// ==== src/mutex_bank.sv ====
/*
 * mutex bank top level
 * two bus ports share a table of lock words through a three stage
 * pipeline: arbiter, lock table and ack stage
 */
`timescale 1ns/10ps

module mutex_bank
	import mutex_pkg::*;
#(
	parameter int MUTEX_COUNT = 32
)
(
	input logic clk,
	input logic rst,

	// port 0
	input logic cs0,
	input logic cyc0,
	input logic stb0,
	input logic we0,
	input logic [ADDR_W-1:0] adr0,
	input logic [DATA_W-1:0] dat_i0,
	output logic ack0,
	output logic [DATA_W-1:0] dat_o0,

	// port 1
	input logic cs1,
	input logic cyc1,
	input logic stb1,
	input logic we1,
	input logic [ADDR_W-1:0] adr1,
	input logic [DATA_W-1:0] dat_i1,
	output logic ack1,
	output logic [DATA_W-1:0] dat_o1
);

	bus_req_t req0;
	bus_req_t req1;
	grant_t grant;
	resp_t resp;
	logic [NUM_PORTS-1:0] done;

	// ============================================================
	// request packing
	// ============================================================

	// a port only requests while cs, cyc and stb are all high
	assign req0.sel = cs0 && cyc0 && stb0;
	assign req0.wr = we0;
	assign req0.addr = adr0;
	assign req0.wdata.raw = dat_i0;

	assign req1.sel = cs1 && cyc1 && stb1;
	assign req1.wr = we1;
	assign req1.addr = adr1;
	assign req1.wdata.raw = dat_i1;

	// ============================================================
	// pipeline
	// ============================================================

	mutex_port_arbiter #(
		.MUTEX_COUNT(MUTEX_COUNT)
	) u_arb (
		.clk(clk),
		.rst(rst),
		.req0(req0),
		.req1(req1),
		.done(done),
		.grant(grant)
	);

	mutex_table #(
		.MUTEX_COUNT(MUTEX_COUNT)
	) u_table (
		.clk(clk),
		.rst(rst),
		.grant(grant),
		.resp(resp)
	);

	// the ack stage closes the loop back to the arbiter through done
	mutex_ack_gen u_ack (
		.clk(clk),
		.rst(rst),
		.resp(resp),
		.req0(req0),
		.req1(req1),
		.ack0(ack0),
		.ack1(ack1),
		.dat_o0(dat_o0),
		.dat_o1(dat_o1),
		.done(done)
	);

endmodule

// ==== src/mutex_ack_gen.sv ====
/*
 * mutex bank ack stage, third pipeline stage
 * registers ack and read data for the granted port, holds them while
 * the port keeps its request up and pulses done when it lets go
 */
`timescale 1ns/10ps

module mutex_ack_gen
	import mutex_pkg::*;
(
	input logic clk,
	input logic rst,
	input resp_t resp,
	input bus_req_t req0,
	input bus_req_t req1,
	output logic ack0,
	output logic ack1,
	output logic [DATA_W-1:0] dat_o0,
	output logic [DATA_W-1:0] dat_o1,
	output logic [NUM_PORTS-1:0] done
);

	logic [NUM_PORTS-1:0] sel;
	logic [NUM_PORTS-1:0] ack_q;
	logic [NUM_PORTS-1:0] done_q;
	logic [DATA_W-1:0] dat_q [NUM_PORTS];

	assign sel = {req1.sel, req0.sel};

	// ============================================================
	// per port ack and data hold
	// ============================================================

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		logic hit;

		// the response is meant for this port
		assign hit = resp.valid && (resp.port == port_id_t'(p));

		always_ff @(posedge clk)
		begin
			if (rst)
			begin
				ack_q[p] <= 1'b0;
				done_q[p] <= 1'b0;
				dat_q[p] <= '0;
			end
			else
			begin
				done_q[p] <= 1'b0;
				if (hit)
				begin
					ack_q[p] <= 1'b1;
					dat_q[p] <= resp.rdata.raw;
				end
				else if (ack_q[p] && !sel[p])
				begin
					// stb fell, so release the bus and tell the arbiter
					ack_q[p] <= 1'b0;
					dat_q[p] <= '0;
					done_q[p] <= 1'b1;
				end
			end
		end
	end

	assign ack0 = ack_q[0];
	assign ack1 = ack_q[1];
	assign dat_o0 = dat_q[0];
	assign dat_o1 = dat_q[1];
	assign done = done_q;

endmodule

// ==== src/mutex_table.sv ====
/*
 * mutex bank lock table, second pipeline stage
 * holds the lock words, applies the ownership rule to writes and
 * passes the word as it stands after the access to the ack stage
 */
`timescale 1ns/10ps

module mutex_table
	import mutex_pkg::*;
#(
	parameter int MUTEX_COUNT = 32
)
(
	input logic clk,
	input logic rst,
	input grant_t grant,
	output resp_t resp
);

	localparam int IDX_W = $clog2(MUTEX_COUNT);

	// ============================================================
	// storage
	// ============================================================

	// every word clears to zero, so all mutexes start unlocked
	mutex_word_u words [MUTEX_COUNT];

	logic [IDX_W-1:0] idx;
	mutex_word_u cur_word;
	mutex_word_u next_word;

	// ============================================================
	// commit rule
	// ============================================================

	// stored word is free, or already belongs to the writer
	logic owner_ok;
	// the written owner field must name the writing port
	logic claim_ok;
	logic commit;

	// registered response
	logic resp_valid;
	port_id_t resp_port;
	mutex_word_u resp_word;

	// the arbiter has already masked the index to the table depth
	assign idx = grant.index[IDX_W-1:0];
	assign cur_word = words[idx];

	assign owner_ok = !cur_word.fields.lock || (cur_word.fields.owner == grant.port);
	assign claim_ok = grant.wdata.fields.owner == grant.port;
	assign commit = grant.valid && grant.wr && owner_ok && claim_ok;

	// the whole written word is kept, spare bits and tag included
	// a read or a refused write hands back the stored word untouched
	assign next_word = commit ? grant.wdata : cur_word;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < MUTEX_COUNT; i++)
			begin
				words[i] <= '0;
			end
			resp_valid <= 1'b0;
		end
		else
		begin
			// resp valid trails grant valid by exactly one edge
			resp_valid <= grant.valid;
			if (commit)
			begin
				words[idx] <= grant.wdata;
			end
		end
	end

	// the master compares owner and lock here with what it wrote
	// to learn whether it won the mutex
	always_ff @(posedge clk)
	begin
		if (grant.valid)
		begin
			resp_port <= grant.port;
			resp_word <= next_word;
		end
	end

	assign resp.valid = resp_valid;
	assign resp.port = resp_port;
	assign resp.rdata = resp_word;

endmodule

// ==== src/mutex_port_arbiter.sv ====
/*
 * mutex bank arbiter, first pipeline stage
 * qualifies each port's select, grants one port with fixed priority
 * for port 0 and captures its access until the holder releases
 */
`timescale 1ns/10ps

module mutex_port_arbiter
	import mutex_pkg::*;
#(
	parameter int MUTEX_COUNT = 32
)
(
	input logic clk,
	input logic rst,
	input bus_req_t req0,
	input bus_req_t req1,
	input logic [NUM_PORTS-1:0] done,
	output grant_t grant
);

	// keeps the index inside the table depth
	localparam logic [MAX_INDEX_W-1:0] INDEX_MASK = MAX_INDEX_W'(MUTEX_COUNT - 1);

	// busy stays set from the grant until the holder's release pulse
	logic busy;
	port_id_t holder;
	logic free;
	logic start;

	// the request that wins this cycle
	bus_req_t pick;
	port_id_t pick_port;

	// captured access
	logic grant_valid;
	logic grant_wr;
	logic [MAX_INDEX_W-1:0] grant_index;
	mutex_word_u grant_wdata;

	// ============================================================
	// selection
	// ============================================================

	// a release from the holder frees the arbiter on the same edge,
	// so a waiting port gets its grant without a dead cycle
	assign free = !busy || done[holder[0]];
	assign start = free && (req0.sel || req1.sel);

	// port 0 always wins a tie
	assign pick = req0.sel ? req0 : req1;
	assign pick_port = req0.sel ? port_id_t'(0) : port_id_t'(1);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			holder <= '0;
			grant_valid <= 1'b0;
		end
		else
		begin
			// grant valid is a single cycle strobe
			grant_valid <= start;
			if (start)
			begin
				busy <= 1'b1;
				holder <= pick_port;
			end
			else if (free)
			begin
				busy <= 1'b0;
			end
		end
	end

	// access fields only load with a new grant
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			grant_wr <= pick.wr;
			grant_index <= pick.addr[ADDR_LSB +: MAX_INDEX_W] & INDEX_MASK;
			grant_wdata <= pick.wdata;
		end
	end

	assign grant.valid = grant_valid;
	assign grant.port = holder;
	assign grant.wr = grant_wr;
	assign grant.index = grant_index;
	assign grant.wdata = grant_wdata;

endmodule

// ==== src/mutex_pkg.sv ====
/*
 * mutex bank shared definitions
 * lock word layout, per-stage pipeline payloads and the bus widths
 * that the arbiter, lock table and ack stage all agree on
 */
package mutex_pkg;

	// ============================================================
	// widths
	// ============================================================

	localparam int ADDR_W = 11;
	localparam int DATA_W = 32;
	localparam int NUM_PORTS = 2;

	// the word index is cut from the address starting at ADDR_LSB
	localparam int MAX_INDEX_W = 5;
	localparam int ADDR_LSB = 2;

	// port 0 is number 0 and port 1 is number 1
	typedef logic [3:0] port_id_t;

	// ============================================================
	// lock word
	// ============================================================

	// lock in bit 0, tag in bits 16..1, owner in bits 20..17
	typedef struct packed {
		logic [10:0] spare;
		port_id_t owner;
		logic [15:0] tag;
		logic lock;
	} lock_fields_t;

	// the bus sees raw data while the table looks at the fields
	typedef union packed {
		logic [DATA_W-1:0] raw;
		lock_fields_t fields;
	} mutex_word_u;

	// ============================================================
	// stage payloads
	// ============================================================

	// one port's request as seen on its bus pins
	typedef struct packed {
		logic sel;
		logic wr;
		logic [ADDR_W-1:0] addr;
		mutex_word_u wdata;
	} bus_req_t;

	// captured access handed from the arbiter to the table
	typedef struct packed {
		logic valid;
		port_id_t port;
		logic wr;
		logic [MAX_INDEX_W-1:0] index;
		mutex_word_u wdata;
	} grant_t;

	// post-access word handed from the table to the ack stage
	typedef struct packed {
		logic valid;
		port_id_t port;
		mutex_word_u rdata;
	} resp_t;

endpackage
